// ==== common/gfx_consts.svh ====
// ========================================
// graphics demo constants for the reduced
// 16x8 video mode and banked framebuffer.
// ========================================
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

`define GFX_COLOR_WIDTH 4

`define GFX_H_ACTIVE 16
`define GFX_H_FRONT 2
`define GFX_H_SYNC 3
`define GFX_H_BACK 3
`define GFX_H_TOTAL (`GFX_H_ACTIVE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK)

`define GFX_V_ACTIVE 8
`define GFX_V_FRONT 1
`define GFX_V_SYNC 2
`define GFX_V_BACK 1
`define GFX_V_TOTAL (`GFX_V_ACTIVE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK)

// banks interleave by x modulo the bank count.
`define GFX_NUM_BANKS 4
`define GFX_BANK_DEPTH 32
`define GFX_BANK_ADDR_WIDTH 5
`define GFX_X_WIDTH 5
`define GFX_Y_WIDTH 4

`endif

// ==== common/gfx_pkg.sv ====
// ========================================
// graphics demo types: pixel word, pattern
// select and raster positions.
// ========================================
`include "gfx_consts.svh"

package gfx_pkg;

  // word stored in each bank.
  typedef struct packed {
    logic [`GFX_COLOR_WIDTH-1:0] red;
    logic [`GFX_COLOR_WIDTH-1:0] grn;
    logic [`GFX_COLOR_WIDTH-1:0] blu;
  } pixel_t;

  typedef enum logic [1:0] {
    pat_bars       = 2'd0,
    pat_checker    = 2'd1,
    pat_diagonal   = 2'd2,
    pat_solid_blue = 2'd3
  } pattern_t;

  typedef logic [`GFX_X_WIDTH-1:0] hpos_t;
  typedef logic [`GFX_Y_WIDTH-1:0] vpos_t;

endpackage

// ==== src/vga_timing.sv ====
// ========================================
// vga timing generator, idle until the
// framebuffer holds a full frame.
// ========================================
`timescale 1ns/1ps
`include "gfx_consts.svh"

module vga_timing (
  input  logic           pixel_clk,
  input  logic           rst_n,
  input  logic           frame_ready,
  output gfx_pkg::hpos_t hpos,
  output gfx_pkg::vpos_t vpos,
  output logic           active,
  output logic           hsync_raw,
  output logic           vsync_raw
);
  import gfx_pkg::*;

  localparam int H_SYNC_START = `GFX_H_ACTIVE + `GFX_H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + `GFX_H_SYNC;
  localparam int V_SYNC_START = `GFX_V_ACTIVE + `GFX_V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + `GFX_V_SYNC;

  hpos_t hcnt;
  vpos_t vcnt;
  logic  h_last;
  logic  v_last;

  assign h_last = (hcnt == hpos_t'(`GFX_H_TOTAL - 1));
  assign v_last = (vcnt == vpos_t'(`GFX_V_TOTAL - 1));

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (frame_ready) begin
      if (h_last) begin
        hcnt <= '0;
        vcnt <= v_last ? '0 : vcnt + 1'b1; // wrap at frame end.
      end else begin
        hcnt <= hcnt + 1'b1;
      end
    end
  end

  assign hpos = hcnt;
  assign vpos = vcnt;

  // counters sit at zero while idle, so gate the decode.
  assign active = frame_ready && (hcnt < `GFX_H_ACTIVE) && (vcnt < `GFX_V_ACTIVE);

  assign hsync_raw = !(frame_ready && (hcnt >= H_SYNC_START) && (hcnt < H_SYNC_END));
  assign vsync_raw = !(frame_ready && (vcnt >= V_SYNC_START) && (vcnt < V_SYNC_END));

endmodule

// ==== framebuffer/fb_pattern_writer.sv ====
// ========================================
// pattern writer, fills the framebuffer
// banks in raster order, one pixel a cycle.
// ========================================
`timescale 1ns/1ps
`include "gfx_consts.svh"

module fb_pattern_writer (
  input  logic                            pixel_clk,
  input  logic                            rst_n,
  input  gfx_pkg::pattern_t               pattern_sel,
  input  logic                            continuous_write,
  output logic [`GFX_NUM_BANKS-1:0]       wr_en,
  output logic [`GFX_BANK_ADDR_WIDTH-1:0] wr_addr,
  output gfx_pkg::pixel_t                 wr_pixel,
  output logic                            frame_ready
);
  import gfx_pkg::*;

  localparam int BANK_BITS     = $clog2(`GFX_NUM_BANKS);
  localparam int COLS_PER_BANK = `GFX_H_ACTIVE / `GFX_NUM_BANKS;

  hpos_t                 x;
  vpos_t                 y;
  logic                  writing;
  logic                  last_pixel;
  logic [BANK_BITS-1:0]  bank;
  logic                  checker_on;

  assign last_pixel = (x == hpos_t'(`GFX_H_ACTIVE - 1)) && (y == vpos_t'(`GFX_V_ACTIVE - 1));

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      x           <= '0;
      y           <= '0;
      writing     <= 1'b1;
      frame_ready <= 1'b0;
    end else if (writing) begin
      if (x == hpos_t'(`GFX_H_ACTIVE - 1)) begin
        x <= '0;
        y <= last_pixel ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
      if (last_pixel) begin
        frame_ready <= 1'b1; // sticky until reset.
        writing     <= continuous_write; // go idle after a full pass.
      end
    end else if (continuous_write) begin
      writing <= 1'b1; // resume at pixel 0.
    end
  end

  // bank is x mod banks, address is y * cols + x / banks.
  assign bank    = x[BANK_BITS-1:0];
  assign wr_addr = `GFX_BANK_ADDR_WIDTH'(y * COLS_PER_BANK + (x >> BANK_BITS));

  always_comb begin
    wr_en       = '0;
    wr_en[bank] = writing;
  end

  assign checker_on = x[1] ^ y[1];

  always_comb begin
    case (pattern_sel)
      pat_bars: begin
        wr_pixel.red = `GFX_COLOR_WIDTH'(x);
        wr_pixel.grn = `GFX_COLOR_WIDTH'(y << 1);
        wr_pixel.blu = '0;
      end
      pat_checker: begin
        wr_pixel.red = {`GFX_COLOR_WIDTH{checker_on}};
        wr_pixel.grn = {`GFX_COLOR_WIDTH{checker_on}};
        wr_pixel.blu = {`GFX_COLOR_WIDTH{checker_on}};
      end
      pat_diagonal: begin
        wr_pixel.red = `GFX_COLOR_WIDTH'(x + y); // mod 16 by truncation.
        wr_pixel.grn = `GFX_COLOR_WIDTH'(x + y);
        wr_pixel.blu = `GFX_COLOR_WIDTH'(x + y);
      end
      default: begin
        wr_pixel.red = '0;
        wr_pixel.grn = '0;
        wr_pixel.blu = '1;
      end
    endcase
  end

endmodule

// ==== framebuffer/fb_bank.sv ====
// ========================================
// framebuffer bank, one pixel column set,
// registered read with old-data semantics.
// ========================================
`timescale 1ns/1ps
`include "gfx_consts.svh"

module fb_bank (
  input  logic                            pixel_clk,
  input  logic                            wr_en,
  input  logic [`GFX_BANK_ADDR_WIDTH-1:0] wr_addr,
  input  gfx_pkg::pixel_t                 wr_pixel,
  input  logic                            rd_en,
  input  logic [`GFX_BANK_ADDR_WIDTH-1:0] rd_addr,
  output gfx_pkg::pixel_t                 rd_pixel,
  output logic                            collision
);
  import gfx_pkg::*;

  pixel_t mem [`GFX_BANK_DEPTH];

  always_ff @(posedge pixel_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_pixel;
    end
  end

  // read sees the word from before a same-cycle write.
  always_ff @(posedge pixel_clk) begin
    if (rd_en) begin
      rd_pixel <= mem[rd_addr];
    end
  end

  // flags the read that lines up with rd_pixel.
  always_ff @(posedge pixel_clk) begin
    collision <= rd_en && wr_en && (rd_addr == wr_addr);
  end

endmodule

// ==== framebuffer/fb_scanout.sv ====
// ========================================
// scanout, reads the banks in raster order
// and drives aligned, blanked vga outputs.
// ========================================
`timescale 1ns/1ps
`include "gfx_consts.svh"

module fb_scanout (
  input  logic                            pixel_clk,
  input  logic                            rst_n,
  input  gfx_pkg::hpos_t                  hpos,
  input  gfx_pkg::vpos_t                  vpos,
  input  logic                            active,
  input  logic                            hsync_raw,
  input  logic                            vsync_raw,
  output logic                            rd_en,
  output logic [`GFX_BANK_ADDR_WIDTH-1:0] rd_addr,
  input  gfx_pkg::pixel_t                 bank_pixel [`GFX_NUM_BANKS],
  input  logic [`GFX_NUM_BANKS-1:0]       bank_collision,
  output logic [`GFX_COLOR_WIDTH-1:0]     vga_red,
  output logic [`GFX_COLOR_WIDTH-1:0]     vga_grn,
  output logic [`GFX_COLOR_WIDTH-1:0]     vga_blu,
  output logic                            vga_hsync,
  output logic                            vga_vsync,
  output logic                            vga_de,
  output logic                            vga_error,
  output logic [15:0]                     error_cnt
);
  import gfx_pkg::*;

  localparam int BANK_BITS     = $clog2(`GFX_NUM_BANKS);
  localparam int COLS_PER_BANK = `GFX_H_ACTIVE / `GFX_NUM_BANKS;

  logic [BANK_BITS-1:0] bank_d1;
  logic                 active_d1;
  logic                 hsync_d1;
  logic                 vsync_d1;
  pixel_t               sel_pixel;

  // same mapping the writer uses.
  assign rd_en   = active;
  assign rd_addr = `GFX_BANK_ADDR_WIDTH'(vpos * COLS_PER_BANK + (hpos >> BANK_BITS));

  // stage 1, matches the bank read latency.
  always_ff @(posedge pixel_clk) begin
    bank_d1 <= hpos[BANK_BITS-1:0];
    if (!rst_n) begin
      active_d1 <= 1'b0;
      hsync_d1  <= 1'b1;
      vsync_d1  <= 1'b1;
    end else begin
      active_d1 <= active;
      hsync_d1  <= hsync_raw;
      vsync_d1  <= vsync_raw;
    end
  end

  assign sel_pixel = bank_pixel[bank_d1];

  // stage 2, output registers.
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_de    <= 1'b0;
      vga_error <= 1'b0;
    end else begin
      vga_red   <= active_d1 ? sel_pixel.red : '0; // blank outside active.
      vga_grn   <= active_d1 ? sel_pixel.grn : '0;
      vga_blu   <= active_d1 ? sel_pixel.blu : '0;
      vga_hsync <= hsync_d1;
      vga_vsync <= vsync_d1;
      vga_de    <= active_d1;
      vga_error <= active_d1 && bank_collision[bank_d1];
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      error_cnt <= '0;
    end else if (vga_error) begin
      error_cnt <= error_cnt + 1'b1; // wraps at 16 bits.
    end
  end

endmodule

// ==== src/gfx_pattern_demo.sv ====
// ========================================
// pattern demo top: writer, banked
// framebuffer, timing and scanout.
// ========================================
`timescale 1ns/1ps
`include "gfx_consts.svh"

module gfx_pattern_demo (
  input  logic                        pixel_clk,
  input  logic                        rst_n,
  input  gfx_pkg::pattern_t           pattern_sel,
  input  logic                        continuous_write,
  output logic [`GFX_COLOR_WIDTH-1:0] vga_red,
  output logic [`GFX_COLOR_WIDTH-1:0] vga_grn,
  output logic [`GFX_COLOR_WIDTH-1:0] vga_blu,
  output logic                        vga_hsync,
  output logic                        vga_vsync,
  output logic                        vga_de,
  output logic                        vga_error,
  output logic [15:0]                 error_cnt
);
  import gfx_pkg::*;

  logic [`GFX_NUM_BANKS-1:0]       wr_en;
  logic [`GFX_BANK_ADDR_WIDTH-1:0] wr_addr;
  pixel_t                          wr_pixel;
  logic                            frame_ready;
  logic                            rd_en;
  logic [`GFX_BANK_ADDR_WIDTH-1:0] rd_addr;
  pixel_t                          bank_pixel [`GFX_NUM_BANKS];
  logic [`GFX_NUM_BANKS-1:0]       bank_collision;
  hpos_t                           hpos;
  vpos_t                           vpos;
  logic                            active;
  logic                            hsync_raw;
  logic                            vsync_raw;

  fb_pattern_writer u_writer (
    .pixel_clk       (pixel_clk),
    .rst_n           (rst_n),
    .pattern_sel     (pattern_sel),
    .continuous_write(continuous_write),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_pixel        (wr_pixel),
    .frame_ready     (frame_ready)
  );

  // one bank per column modulo the bank count.
  for (genvar i = 0; i < `GFX_NUM_BANKS; i++) begin : g_bank
    fb_bank u_bank (
      .pixel_clk(pixel_clk),
      .wr_en    (wr_en[i]),
      .wr_addr  (wr_addr),
      .wr_pixel (wr_pixel),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_pixel (bank_pixel[i]),
      .collision(bank_collision[i])
    );
  end

  vga_timing u_timing (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .frame_ready(frame_ready),
    .hpos       (hpos),
    .vpos       (vpos),
    .active     (active),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw)
  );

  fb_scanout u_scanout (
    .pixel_clk     (pixel_clk),
    .rst_n         (rst_n),
    .hpos          (hpos),
    .vpos          (vpos),
    .active        (active),
    .hsync_raw     (hsync_raw),
    .vsync_raw     (vsync_raw),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .bank_pixel    (bank_pixel),
    .bank_collision(bank_collision),
    .vga_red       (vga_red),
    .vga_grn       (vga_grn),
    .vga_blu       (vga_blu),
    .vga_hsync     (vga_hsync),
    .vga_vsync     (vga_vsync),
    .vga_de        (vga_de),
    .vga_error     (vga_error),
    .error_cnt     (error_cnt)
  );

endmodule

// ==== testbench/gfx_pattern_demo_assertions.sv ====
// ========================================
// bound checks on the demo vga outputs.
// ========================================
`timescale 1ns/1ps
`include "gfx_consts.svh"

module gfx_pattern_demo_assertions (
  input logic                        pixel_clk,
  input logic                        rst_n,
  input logic [`GFX_COLOR_WIDTH-1:0] vga_red,
  input logic [`GFX_COLOR_WIDTH-1:0] vga_grn,
  input logic [`GFX_COLOR_WIDTH-1:0] vga_blu,
  input logic                        vga_hsync,
  input logic                        vga_vsync,
  input logic                        vga_de,
  input logic                        vga_error,
  input logic [15:0]                 error_cnt
);

  int fail_count = 0;

  a_de_outside_sync: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    vga_de |-> (vga_hsync && vga_vsync))
    else begin
      fail_count++;
      $error("data enable high during a sync pulse");
    end

  // blanking outside the active area.
  a_blank_colors: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    !vga_de |-> (vga_red == '0 && vga_grn == '0 && vga_blu == '0))
    else begin
      fail_count++;
      $error("colors not zero while data enable is low");
    end

  a_cnt_follows_error: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    !$stable(error_cnt) |-> $past(vga_error))
    else begin
      fail_count++;
      $error("error counter moved without a preceding error pulse");
    end

endmodule

bind gfx_pattern_demo gfx_pattern_demo_assertions u_assertions (
  .pixel_clk(pixel_clk),
  .rst_n    (rst_n),
  .vga_red  (vga_red),
  .vga_grn  (vga_grn),
  .vga_blu  (vga_blu),
  .vga_hsync(vga_hsync),
  .vga_vsync(vga_vsync),
  .vga_de   (vga_de),
  .vga_error(vga_error),
  .error_cnt(error_cnt)
);

// ==== testbench/gfx_pattern_demo_tb.sv ====
// ========================================
// pattern demo testbench. applies a table
// of pattern rows and checks each frame.
// ========================================
`timescale 1ns/1ps
`include "gfx_consts.svh"

module gfx_pattern_demo_tb;
  import gfx_pkg::*;

  localparam int WAIT_LIMIT = 1000;
  localparam int NUM_ROWS   = 11;
  localparam int FIRST_RAND = 7;

  typedef struct packed {
    pattern_t sel;
    logic     cw;
    pattern_t shown;
  } stim_row_t;

  // first rows in fixed order, the rest get shuffled.
  stim_row_t stim_rows [NUM_ROWS] = '{
    '{pat_bars, 1'b1, pat_bars},
    '{pat_checker, 1'b1, pat_checker},
    '{pat_diagonal, 1'b1, pat_diagonal},
    '{pat_solid_blue, 1'b1, pat_solid_blue},
    '{pat_solid_blue, 1'b0, pat_solid_blue},
    '{pat_checker, 1'b0, pat_solid_blue},
    '{pat_bars, 1'b0, pat_solid_blue},
    '{pat_bars, 1'b1, pat_bars},
    '{pat_checker, 1'b1, pat_checker},
    '{pat_diagonal, 1'b1, pat_diagonal},
    '{pat_solid_blue, 1'b1, pat_solid_blue}
  };

  logic                        pixel_clk;
  logic                        rst_n;
  pattern_t                    pattern_sel;
  logic                        continuous_write;
  logic [`GFX_COLOR_WIDTH-1:0] vga_red;
  logic [`GFX_COLOR_WIDTH-1:0] vga_grn;
  logic [`GFX_COLOR_WIDTH-1:0] vga_blu;
  logic                        vga_hsync;
  logic                        vga_vsync;
  logic                        vga_de;
  logic                        vga_error;
  logic [15:0]                 error_cnt;
  logic [15:0]                 last_cnt;
  int                          seed = 51;
  int                          r;
  int                          j;
  stim_row_t                   tmp;

  gfx_pattern_demo dut (
    .pixel_clk       (pixel_clk),
    .rst_n           (rst_n),
    .pattern_sel     (pattern_sel),
    .continuous_write(continuous_write),
    .vga_red         (vga_red),
    .vga_grn         (vga_grn),
    .vga_blu         (vga_blu),
    .vga_hsync       (vga_hsync),
    .vga_vsync       (vga_vsync),
    .vga_de          (vga_de),
    .vga_error       (vga_error),
    .error_cnt       (error_cnt)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #20 pixel_clk = ~pixel_clk;
  end

  task automatic check_value(input string what, input int got, input int want);
    if (got != want) begin
      $display("ERROR at %0t: %s, got %0d, expected %0d", $time, what, got, want);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    $display(">>> FAIL");
    $fatal(1, "run stopped on timeout");
  endtask

  task automatic report_assertion_failure();
    $display("a bound assertion on the vga outputs failed");
    $display(">>> FAIL");
    $fatal(1, "assertion failure");
  endtask

  // reference pattern packed as red, green, blue.
  function automatic logic [11:0] expected_pixel(input pattern_t p, input int x, input int y);
    int c_r;
    int c_g;
    int c_b;
    case (p)
      pat_bars: begin
        c_r = x;
        c_g = 2 * y;
        c_b = 0;
      end
      pat_checker: begin
        c_r = (((x / 2) % 2) != ((y / 2) % 2)) ? 15 : 0;
        c_g = c_r;
        c_b = c_r;
      end
      pat_diagonal: begin
        c_r = (x + y) % 16;
        c_g = c_r;
        c_b = c_r;
      end
      default: begin
        c_r = 0;
        c_g = 0;
        c_b = 15;
      end
    endcase
    return {4'(c_r), 4'(c_g), 4'(c_b)};
  endfunction

  task automatic check_idle();
    int n;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(negedge pixel_clk);
      if (vga_de) return; // display has started.
      check_value("idle hsync", int'(vga_hsync), 1);
      check_value("idle vsync", int'(vga_vsync), 1);
      check_value("idle error", int'(vga_error), 0);
      check_value("idle colors", int'({vga_red, vga_grn, vga_blu}), 0);
      check_value("idle error_cnt", int'(error_cnt), 0);
    end
    report_timeout("display never started after reset");
  endtask

  task automatic wait_vsync_fall();
    logic prev;
    int   n;
    @(negedge pixel_clk);
    prev = vga_vsync;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(negedge pixel_clk);
      if (prev && !vga_vsync) return;
      prev = vga_vsync;
    end
    report_timeout("no vsync falling edge");
  endtask

  // starts on the sample where vsync just fell, runs to the next fall.
  task automatic capture_frame(input pattern_t shown, input logic frozen);
    int          x;
    int          y;
    int          n;
    int          hs_run;
    int          hs_pulses;
    int          vs_low;
    int          vs_pulses;
    logic        done;
    logic        prev_de;
    logic        prev_hs;
    logic        prev_vs;
    logic [15:0] cnt_start;
    x = 0;
    y = 0;
    n = 0;
    hs_run = 0;
    hs_pulses = 0;
    vs_low = 1;
    vs_pulses = 0;
    done = 1'b0;
    prev_de = 1'b0;
    prev_hs = 1'b1;
    prev_vs = 1'b0;
    cnt_start = error_cnt;
    while (!done && n < WAIT_LIMIT) begin
      @(negedge pixel_clk);
      n++;
      if (prev_vs && !vga_vsync) begin
        done = 1'b1;
      end else begin
        if (!vga_vsync) vs_low++;
        if (!prev_vs && vga_vsync) vs_pulses++;
        if (!vga_hsync) begin
          hs_run++;
        end else if (!prev_hs) begin
          check_value("hsync pulse width", hs_run, `GFX_H_SYNC);
          hs_pulses++;
          hs_run = 0;
        end
        if (vga_de) begin
          check_value($sformatf("pixel (%0d,%0d) of %s", x, y, shown.name()),
                      int'({vga_red, vga_grn, vga_blu}), int'(expected_pixel(shown, x, y)));
          x++;
        end else if (prev_de) begin
          check_value("de cycles in line", x, `GFX_H_ACTIVE); // end of a line.
          y++;
          x = 0;
        end
        prev_de = vga_de;
        prev_hs = vga_hsync;
        prev_vs = vga_vsync;
      end
    end
    if (!done) report_timeout("frame capture never reached the next vsync");
    check_value("lines with de", y, `GFX_V_ACTIVE);
    check_value("hsync pulses per frame", hs_pulses, `GFX_V_TOTAL);
    check_value("vsync pulses per frame", vs_pulses, 1);
    check_value("vsync low cycles", vs_low, `GFX_V_SYNC * `GFX_H_TOTAL);
    if (frozen) check_value("error_cnt while frozen", int'(error_cnt), int'(cnt_start));
  endtask

  // counter only steps by one, wrapping at 16 bits.
  always @(negedge pixel_clk) begin
    if (rst_n && error_cnt != last_cnt) begin
      check_value("error_cnt step", int'(error_cnt), int'(16'(last_cnt + 16'd1)));
    end
    last_cnt = error_cnt;
  end

  always @(negedge pixel_clk) begin
    if (dut.u_assertions.fail_count != 0) report_assertion_failure();
  end

  initial begin
    rst_n = 1'b0;
    pattern_sel = pat_bars;
    continuous_write = 1'b1;
    last_cnt = '0;
    for (r = NUM_ROWS - 1; r > FIRST_RAND; r--) begin
      j = FIRST_RAND + int'($unsigned($random(seed)) % (r - FIRST_RAND + 1));
      tmp = stim_rows[r];
      stim_rows[r] = stim_rows[j];
      stim_rows[j] = tmp;
    end
    repeat (3) @(posedge pixel_clk);
    rst_n <= 1'b1;
    check_idle();
    for (r = 0; r < NUM_ROWS; r++) begin
      @(posedge pixel_clk);
      pattern_sel <= stim_rows[r].sel;
      continuous_write <= stim_rows[r].cw;
      wait_vsync_fall();
      wait_vsync_fall();
      capture_frame(stim_rows[r].shown, !stim_rows[r].cw);
    end
    if (dut.u_assertions.fail_count != 0) begin
      report_assertion_failure();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== list.f ====
+incdir+common
common/gfx_pkg.sv
src/vga_timing.sv
framebuffer/fb_pattern_writer.sv
framebuffer/fb_bank.sv
framebuffer/fb_scanout.sv
src/gfx_pattern_demo.sv
testbench/gfx_pattern_demo_assertions.sv
testbench/gfx_pattern_demo_tb.sv

// ==== Makefile ====
# Verilator build for the framebuffer pattern demo.
# The simulator exit status carries the test result.

TOP := gfx_pattern_demo_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
